/* verilog/ppc_ctrl_pkg.sv */
//****************************************
// shared types for the pipeline control
// field positions, opcodes, control enums
// and the per-stage control structs
//****************************************

package ppc_ctrl_pkg;

	// instruction words are numbered big-endian, bit 0 is the msb
	typedef logic [0:31] instr_t;
	typedef logic [5:0]  opcd_t;
	typedef logic [9:0]  xo_t;
	typedef logic [8:0]  xoxo_t;

	localparam int OPCD_MSB = 0;
	localparam int XO_MSB   = 21;
	localparam int XOXO_MSB = 22; // bit 21 is OE in XO-form
	localparam int RC_BIT   = 31;

	localparam opcd_t OPCD_CMPLI = 6'd10;
	localparam opcd_t OPCD_CMPI  = 6'd11;
	localparam opcd_t OPCD_ADDI  = 6'd14;
	localparam opcd_t OPCD_ADDIS = 6'd15;
	localparam opcd_t OPCD_BC    = 6'd16;
	localparam opcd_t OPCD_B     = 6'd18;
	localparam opcd_t OPCD_ORI   = 6'd24;
	localparam opcd_t OPCD_XORI  = 6'd26;
	localparam opcd_t OPCD_ANDI  = 6'd28; // andi. always records
	localparam opcd_t OPCD_X31   = 6'd31;
	localparam opcd_t OPCD_LWZ   = 6'd32;
	localparam opcd_t OPCD_LBZ   = 6'd34;
	localparam opcd_t OPCD_STW   = 6'd36;
	localparam opcd_t OPCD_STB   = 6'd38;
	localparam opcd_t OPCD_LHZ   = 6'd40;
	localparam opcd_t OPCD_LHA   = 6'd42;
	localparam opcd_t OPCD_STH   = 6'd44;

	// X-form extended opcodes under primary 31
	localparam xo_t XO_CMP  = 10'd0;
	localparam xo_t XO_AND  = 10'd28;
	localparam xo_t XO_CMPL = 10'd32;
	localparam xo_t XO_XOR  = 10'd316;
	localparam xo_t XO_OR   = 10'd444;

	localparam xoxo_t XOXO_SUBF = 9'd40;
	localparam xoxo_t XOXO_ADD  = 9'd266;

	localparam instr_t INSTR_NOP = 32'h6000_0000; // ori 0,0,0

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUBF,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_op_e;

	typedef enum logic [1:0] {
		EXT_SIGNED,
		EXT_UNSIGN,
		EXT_HIGH16
	} ext_op_e;

	typedef enum logic [1:0] {CMP_NONE, CMP_CMP, CMP_CMPL} cmp_op_e;

	typedef enum logic {B_REG, B_IMM} b_sel_e;

	typedef enum logic [1:0] {NPC_PLUS4, NPC_B, NPC_BC} npc_op_e;

	typedef enum logic [2:0] {
		LD_NONE,
		LD_LW,
		LD_LH,
		LD_LHA,
		LD_LB
	} load_op_e;

	typedef enum logic [1:0] {ST_NONE, ST_SW, ST_SH, ST_SB} store_op_e;

	typedef enum logic {WD_ALU, WD_MEM} wd_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		ext_op_e ext_op;
		cmp_op_e cmp_op;
		b_sel_e  b_sel;
		logic    a_zero; // use 0 instead of RA
	} ex_ctrl_t;

	typedef struct packed {
		logic      dm_wr;
		load_op_e  load_op;
		store_op_e store_op;
	} mem_ctrl_t;

	typedef struct packed {
		logic    gpr_wr;
		wd_sel_e wd_sel;
		logic    waddr_ra; // logical ops write RA, not RT
		logic    cr_wr;
	} wb_ctrl_t;

endpackage

/* verilog/instr_decoder.sv */
//****************************************
// one-shot decode of an instruction word
// into E, MEM and W control
//****************************************

`timescale 1ns/1ps

module instr_decoder import ppc_ctrl_pkg::*; (
	input  instr_t    instr,
	output ex_ctrl_t  ex_ctrl,
	output mem_ctrl_t mem_ctrl,
	output wb_ctrl_t  wb_ctrl,
	output npc_op_e   npc_op,
	output logic      is_branch
);

	opcd_t opcd;
	xo_t   xo;
	xoxo_t xoxo;
	logic  rc;

	assign opcd = instr[OPCD_MSB +: $bits(opcd_t)];
	assign xo   = instr[XO_MSB +: $bits(xo_t)];
	assign xoxo = instr[XOXO_MSB +: $bits(xoxo_t)];
	assign rc   = instr[RC_BIT];

	always_comb begin
		// inactive by default, alu_op stays ADD
		ex_ctrl   = '0;
		mem_ctrl  = '0;
		wb_ctrl   = '0;
		npc_op    = NPC_PLUS4;
		is_branch = 1'b0;
		ex_ctrl.alu_op = ALU_ADD;

		case (opcd)
			OPCD_ADDI, OPCD_ADDIS: begin
				ex_ctrl.b_sel  = B_IMM;
				ex_ctrl.a_zero = 1'b1;
				wb_ctrl.gpr_wr = 1'b1;
				if (opcd == OPCD_ADDIS)
					ex_ctrl.ext_op = EXT_HIGH16;
			end
			OPCD_ORI, OPCD_XORI, OPCD_ANDI: begin
				ex_ctrl.ext_op = EXT_UNSIGN;
				ex_ctrl.b_sel  = B_IMM;
				wb_ctrl.gpr_wr   = 1'b1;
				wb_ctrl.waddr_ra = 1'b1;
				case (opcd)
					OPCD_ORI:  ex_ctrl.alu_op = ALU_OR;
					OPCD_XORI: ex_ctrl.alu_op = ALU_XOR;
					default: begin
						ex_ctrl.alu_op = ALU_AND;
						wb_ctrl.cr_wr  = 1'b1;
					end
				endcase
			end
			OPCD_CMPI, OPCD_CMPLI: begin
				ex_ctrl.b_sel = B_IMM;
				wb_ctrl.cr_wr = 1'b1;
				if (opcd == OPCD_CMPLI) begin
					ex_ctrl.cmp_op = CMP_CMPL;
					ex_ctrl.ext_op = EXT_UNSIGN;
				end else begin
					ex_ctrl.cmp_op = CMP_CMP;
				end
			end
			OPCD_LWZ, OPCD_LHZ, OPCD_LHA, OPCD_LBZ: begin
				ex_ctrl.b_sel  = B_IMM; // d(RA|0) addressing
				ex_ctrl.a_zero = 1'b1;
				wb_ctrl.gpr_wr = 1'b1;
				wb_ctrl.wd_sel = WD_MEM;
				case (opcd)
					OPCD_LWZ: mem_ctrl.load_op = LD_LW;
					OPCD_LHZ: mem_ctrl.load_op = LD_LH;
					OPCD_LHA: mem_ctrl.load_op = LD_LHA;
					default:  mem_ctrl.load_op = LD_LB;
				endcase
			end
			OPCD_STW, OPCD_STH, OPCD_STB: begin
				ex_ctrl.b_sel  = B_IMM;
				ex_ctrl.a_zero = 1'b1;
				mem_ctrl.dm_wr = 1'b1;
				case (opcd)
					OPCD_STW: mem_ctrl.store_op = ST_SW;
					OPCD_STH: mem_ctrl.store_op = ST_SH;
					default:  mem_ctrl.store_op = ST_SB;
				endcase
			end
			OPCD_B: begin
				npc_op    = NPC_B;
				is_branch = 1'b1;
			end
			OPCD_BC: begin
				npc_op    = NPC_BC;
				is_branch = 1'b1;
			end
			OPCD_X31: begin
				case (xo)
					XO_AND, XO_OR, XO_XOR: begin
						wb_ctrl.gpr_wr   = 1'b1;
						wb_ctrl.waddr_ra = 1'b1;
						wb_ctrl.cr_wr    = rc;
						ex_ctrl.alu_op = (xo == XO_AND) ? ALU_AND :
							(xo == XO_OR) ? ALU_OR : ALU_XOR;
					end
					XO_CMP: begin
						ex_ctrl.cmp_op = CMP_CMP;
						wb_ctrl.cr_wr  = 1'b1;
					end
					XO_CMPL: begin
						ex_ctrl.cmp_op = CMP_CMPL;
						wb_ctrl.cr_wr  = 1'b1;
					end
					default: begin
						// XO-form, OE bit ignored
						if (xoxo == XOXO_ADD || xoxo == XOXO_SUBF) begin
							ex_ctrl.alu_op = (xoxo == XOXO_SUBF) ? ALU_SUBF : ALU_ADD;
							wb_ctrl.gpr_wr = 1'b1;
							wb_ctrl.cr_wr  = rc;
						end
					end
				endcase
			end
			default: ;
		endcase
	end

endmodule

/* verilog/decode_stage.sv */
//****************************************
// D stage: decode, branch flush, next-PC
// select and fetch-slot squash
//****************************************

`timescale 1ns/1ps

module decode_stage import ppc_ctrl_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  instr_t    instr_d,
	output logic      valid_d,
	output logic      insn_ok_d,
	output logic      br_flush,
	output npc_op_e   npc_op,
	output ex_ctrl_t  ex_ctrl_d,
	output mem_ctrl_t mem_ctrl_d,
	output wb_ctrl_t  wb_ctrl_d
);

	npc_op_e dec_npc_op;
	logic    is_branch;
	logic    squash_fb;
	logic    squash_fe;

	instr_decoder u_dec (
		.instr     (instr_d),
		.ex_ctrl   (ex_ctrl_d),
		.mem_ctrl  (mem_ctrl_d),
		.wb_ctrl   (wb_ctrl_d),
		.npc_op    (dec_npc_op),
		.is_branch (is_branch)
	);

	assign insn_ok_d = valid_d && (instr_d != INSTR_NOP);
	assign br_flush  = insn_ok_d && is_branch;
	assign npc_op    = br_flush ? dec_npc_op : NPC_PLUS4;

	// delay slot stays valid, the two slots after it are killed
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			squash_fb <= 1'b0;
			squash_fe <= 1'b0;
			valid_d   <= 1'b0;
		end else begin
			squash_fb <= br_flush;
			squash_fe <= br_flush | squash_fb;
			valid_d   <= ~squash_fe;
		end
	end

endmodule

/* verilog/execute_stage.sv */
//****************************************
// E stage register and E control outputs
//****************************************

`timescale 1ns/1ps

module execute_stage import ppc_ctrl_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      valid_d,
	input  logic      insn_ok_d,
	input  ex_ctrl_t  ex_ctrl_d,
	input  mem_ctrl_t mem_ctrl_d,
	input  wb_ctrl_t  wb_ctrl_d,
	output logic      valid_e,
	output logic      insn_ok_e,
	output ex_ctrl_t  ex_ctrl,
	output mem_ctrl_t mem_ctrl_e,
	output wb_ctrl_t  wb_ctrl_e
);

	ex_ctrl_t ex_ctrl_e;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_e    <= 1'b0;
			insn_ok_e  <= 1'b0;
			ex_ctrl_e  <= '0;
			mem_ctrl_e <= '0;
			wb_ctrl_e  <= '0;
		end else begin
			valid_e    <= valid_d;
			insn_ok_e  <= insn_ok_d;
			ex_ctrl_e  <= ex_ctrl_d;
			mem_ctrl_e <= mem_ctrl_d;
			wb_ctrl_e  <= wb_ctrl_d;
		end
	end

	always_comb begin
		ex_ctrl = ex_ctrl_e;
		if (!insn_ok_e)
			ex_ctrl.b_sel = B_REG; // bubbles read the register operand
	end

endmodule

/* verilog/memory_stage.sv */
//****************************************
// MB and ME registers, data memory control
//****************************************

`timescale 1ns/1ps

module memory_stage import ppc_ctrl_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      valid_e,
	input  logic      insn_ok_e,
	input  mem_ctrl_t mem_ctrl_e,
	input  wb_ctrl_t  wb_ctrl_e,
	output logic      valid_mb,
	output logic      valid_me,
	output logic      insn_ok_me,
	output mem_ctrl_t mem_ctrl,
	output wb_ctrl_t  wb_ctrl_me
);

	logic      insn_ok_mb;
	mem_ctrl_t mem_ctrl_mb;
	mem_ctrl_t mem_ctrl_me;
	wb_ctrl_t  wb_ctrl_mb;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_mb    <= 1'b0;
			insn_ok_mb  <= 1'b0;
			mem_ctrl_mb <= '0;
			wb_ctrl_mb  <= '0;
			valid_me    <= 1'b0;
			insn_ok_me  <= 1'b0;
			mem_ctrl_me <= '0;
			wb_ctrl_me  <= '0;
		end else begin
			valid_mb    <= valid_e; // address phase
			insn_ok_mb  <= insn_ok_e;
			mem_ctrl_mb <= mem_ctrl_e;
			wb_ctrl_mb  <= wb_ctrl_e;
			valid_me    <= valid_mb; // data phase
			insn_ok_me  <= insn_ok_mb;
			mem_ctrl_me <= mem_ctrl_mb;
			wb_ctrl_me  <= wb_ctrl_mb;
		end
	end

	always_comb begin
		mem_ctrl = mem_ctrl_me;
		mem_ctrl.dm_wr = mem_ctrl_me.dm_wr & insn_ok_me;
	end

endmodule

/* verilog/writeback_stage.sv */
//****************************************
// W register, GPR and CR write controls
//****************************************

`timescale 1ns/1ps

module writeback_stage import ppc_ctrl_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     valid_me,
	input  logic     insn_ok_me,
	input  wb_ctrl_t wb_ctrl_me,
	output logic     valid_w,
	output wb_ctrl_t wb_ctrl
);

	logic     insn_ok_w;
	wb_ctrl_t wb_ctrl_w;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_w   <= 1'b0;
			insn_ok_w <= 1'b0;
			wb_ctrl_w <= '0;
		end else begin
			valid_w   <= valid_me;
			insn_ok_w <= insn_ok_me;
			wb_ctrl_w <= wb_ctrl_me;
		end
	end

	// selects pass through, only the write enables are qualified
	always_comb begin
		wb_ctrl        = wb_ctrl_w;
		wb_ctrl.gpr_wr = wb_ctrl_w.gpr_wr & insn_ok_w;
		wb_ctrl.cr_wr  = wb_ctrl_w.cr_wr & insn_ok_w;
	end

endmodule

/* verilog/pipe_ctrl_top.sv */
//****************************************
// pipeline control top, D to W stages
//****************************************

`timescale 1ns/1ps

module pipe_ctrl_top import ppc_ctrl_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  instr_t    instr_d,
	output logic      valid_d,
	output logic      valid_e,
	output logic      valid_mb,
	output logic      valid_me,
	output logic      valid_w,
	output logic      br_flush,
	output npc_op_e   npc_op,
	output ex_ctrl_t  ex_ctrl,
	output mem_ctrl_t mem_ctrl,
	output wb_ctrl_t  wb_ctrl
);

	logic      insn_ok_d;
	logic      insn_ok_e;
	logic      insn_ok_me;
	ex_ctrl_t  ex_ctrl_d;
	mem_ctrl_t mem_ctrl_d;
	mem_ctrl_t mem_ctrl_e;
	wb_ctrl_t  wb_ctrl_d;
	wb_ctrl_t  wb_ctrl_e;
	wb_ctrl_t  wb_ctrl_me;

	decode_stage u_d (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr_d    (instr_d),
		.valid_d    (valid_d),
		.insn_ok_d  (insn_ok_d),
		.br_flush   (br_flush),
		.npc_op     (npc_op),
		.ex_ctrl_d  (ex_ctrl_d),
		.mem_ctrl_d (mem_ctrl_d),
		.wb_ctrl_d  (wb_ctrl_d)
	);

	execute_stage u_e (
		.clk        (clk),
		.rst_n      (rst_n),
		.valid_d    (valid_d),
		.insn_ok_d  (insn_ok_d),
		.ex_ctrl_d  (ex_ctrl_d),
		.mem_ctrl_d (mem_ctrl_d),
		.wb_ctrl_d  (wb_ctrl_d),
		.valid_e    (valid_e),
		.insn_ok_e  (insn_ok_e),
		.ex_ctrl    (ex_ctrl),
		.mem_ctrl_e (mem_ctrl_e),
		.wb_ctrl_e  (wb_ctrl_e)
	);

	memory_stage u_m (
		.clk        (clk),
		.rst_n      (rst_n),
		.valid_e    (valid_e),
		.insn_ok_e  (insn_ok_e),
		.mem_ctrl_e (mem_ctrl_e),
		.wb_ctrl_e  (wb_ctrl_e),
		.valid_mb   (valid_mb),
		.valid_me   (valid_me),
		.insn_ok_me (insn_ok_me),
		.mem_ctrl   (mem_ctrl),
		.wb_ctrl_me (wb_ctrl_me)
	);

	writeback_stage u_w (
		.clk        (clk),
		.rst_n      (rst_n),
		.valid_me   (valid_me),
		.insn_ok_me (insn_ok_me),
		.wb_ctrl_me (wb_ctrl_me),
		.valid_w    (valid_w),
		.wb_ctrl    (wb_ctrl)
	);

endmodule

/* bench/pipe_ctrl_asserts.sv */
//****************************************
// concurrent checks bound into the top
// valid chain, dm_wr and br_flush rules
//****************************************

`timescale 1ns/1ps

module pipe_ctrl_asserts import ppc_ctrl_pkg::*; (
	input logic      clk,
	input logic      rst_n,
	input logic      valid_d,
	input logic      valid_e,
	input logic      valid_mb,
	input logic      valid_me,
	input logic      valid_w,
	input logic      br_flush,
	input mem_ctrl_t mem_ctrl
);

	// each stage valid follows the stage before it
	a_valid_e: assert property (@(posedge clk) disable iff (!rst_n)
		valid_e == $past(valid_d)) else $error("valid_e does not follow valid_d");
	a_valid_mb: assert property (@(posedge clk) disable iff (!rst_n)
		valid_mb == $past(valid_e)) else $error("valid_mb does not follow valid_e");
	a_valid_me: assert property (@(posedge clk) disable iff (!rst_n)
		valid_me == $past(valid_mb)) else $error("valid_me does not follow valid_mb");
	a_valid_w: assert property (@(posedge clk) disable iff (!rst_n)
		valid_w == $past(valid_me)) else $error("valid_w does not follow valid_me");

	a_dm_wr: assert property (@(posedge clk) disable iff (!rst_n)
		mem_ctrl.dm_wr |-> valid_me) else $error("dm_wr without valid_me");
	a_flush: assert property (@(posedge clk) disable iff (!rst_n)
		br_flush |-> valid_d) else $error("br_flush without valid_d");

endmodule

bind pipe_ctrl_top pipe_ctrl_asserts u_asserts (.*);

/* bench/pipe_ctrl_tb.sv */
//****************************************
// table-driven testbench for pipe_ctrl_top
// clock, reset, stimulus, checks, watchdog
//****************************************

`timescale 1ns/1ps

module pipe_ctrl_tb import ppc_ctrl_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int NUM_ROWS   = 28;

	typedef struct packed {
		instr_t    word;
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
		npc_op_e   npc;
	} row_t;

	typedef struct packed {
		logic      valid;
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
		npc_op_e   npc;
	} slot_t;

	logic      clk;
	logic      rst_n;
	instr_t    instr_d;
	logic      valid_d, valid_e, valid_mb, valid_me, valid_w;
	logic      br_flush;
	npc_op_e   npc_op;
	ex_ctrl_t  ex_ctrl;
	mem_ctrl_t mem_ctrl;
	wb_ctrl_t  wb_ctrl;

	row_t  table_rows [NUM_ROWS];
	slot_t hist [$]; // expected controls per D slot
	logic  killed [0:255];
	int    n_rows;
	int    seed;

	pipe_ctrl_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#((NUM_ROWS + 20) * CLK_PERIOD);
		$display("timeout: the pipeline run did not finish in time");
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

	function automatic instr_t d_form(opcd_t op, logic [4:0] rt, logic [4:0] ra,
		logic [15:0] imm);
		return {op, rt, ra, imm};
	endfunction

	function automatic instr_t x_form(xo_t xo, logic rc);
		return {OPCD_X31, 5'd3, 5'd4, 5'd5, xo, rc};
	endfunction

	function automatic instr_t xo_form(xoxo_t xoxo, logic rc);
		return {OPCD_X31, 5'd3, 5'd4, 5'd5, 1'b0, xoxo, rc}; // OE clear
	endfunction

	function automatic ex_ctrl_t ex_exp(alu_op_e a, ext_op_e e, cmp_op_e c, b_sel_e b,
		logic z);
		return '{a, e, c, b, z};
	endfunction

	function automatic mem_ctrl_t mem_exp(logic wr, load_op_e ld, store_op_e st);
		return '{wr, ld, st};
	endfunction

	function automatic wb_ctrl_t wb_exp(logic gpr, wd_sel_e sel, logic ra, logic cr);
		return '{gpr, sel, ra, cr};
	endfunction

	task automatic add_row(instr_t w, ex_ctrl_t ex, mem_ctrl_t mem, wb_ctrl_t wb,
		npc_op_e npc);
		table_rows[n_rows] = '{w, ex, mem, wb, npc};
		n_rows++;
	endtask

	task automatic fill_table();
		ex_ctrl_t  ex_ri, ex_rr, ex_ls, ex_nop;
		mem_ctrl_t m0;
		wb_ctrl_t  wb_none, wb_alu, wb_lg, wb_cr, wb_ld, wb_nop;
		ex_ri   = ex_exp(ALU_ADD, EXT_SIGNED, CMP_NONE, B_IMM, 1'b1);
		ex_rr   = ex_exp(ALU_ADD, EXT_SIGNED, CMP_NONE, B_REG, 1'b0);
		ex_ls   = ex_ri; // loads and stores address d(RA|0)
		ex_nop  = ex_exp(ALU_OR, EXT_UNSIGN, CMP_NONE, B_REG, 1'b0);
		m0      = mem_exp(1'b0, LD_NONE, ST_NONE);
		wb_none = wb_exp(1'b0, WD_ALU, 1'b0, 1'b0);
		wb_alu  = wb_exp(1'b1, WD_ALU, 1'b0, 1'b0);
		wb_lg   = wb_exp(1'b1, WD_ALU, 1'b1, 1'b0);
		wb_cr   = wb_exp(1'b0, WD_ALU, 1'b0, 1'b1);
		wb_ld   = wb_exp(1'b1, WD_MEM, 1'b0, 1'b0);
		wb_nop  = wb_exp(1'b0, WD_ALU, 1'b1, 1'b0);
		add_row(d_form(OPCD_ADDI, 5'd3, 5'd4, 16'h0010), ex_ri, m0, wb_alu, NPC_PLUS4);
		add_row(d_form(OPCD_ADDIS, 5'd3, 5'd4, 16'h0001),
			ex_exp(ALU_ADD, EXT_HIGH16, CMP_NONE, B_IMM, 1'b1), m0, wb_alu, NPC_PLUS4);
		add_row(d_form(OPCD_ORI, 5'd3, 5'd4, 16'h0055),
			ex_exp(ALU_OR, EXT_UNSIGN, CMP_NONE, B_IMM, 1'b0), m0, wb_lg, NPC_PLUS4);
		add_row(d_form(OPCD_XORI, 5'd3, 5'd4, 16'h00aa),
			ex_exp(ALU_XOR, EXT_UNSIGN, CMP_NONE, B_IMM, 1'b0), m0, wb_lg, NPC_PLUS4);
		add_row(d_form(OPCD_ANDI, 5'd3, 5'd4, 16'h00ff),
			ex_exp(ALU_AND, EXT_UNSIGN, CMP_NONE, B_IMM, 1'b0), m0,
			wb_exp(1'b1, WD_ALU, 1'b1, 1'b1), NPC_PLUS4);
		// same add with Rc clear then set
		add_row(xo_form(XOXO_ADD, 1'b0), ex_rr, m0, wb_alu, NPC_PLUS4);
		add_row(xo_form(XOXO_ADD, 1'b1), ex_rr, m0, wb_exp(1'b1, WD_ALU, 1'b0, 1'b1),
			NPC_PLUS4);
		add_row(xo_form(XOXO_SUBF, 1'b0),
			ex_exp(ALU_SUBF, EXT_SIGNED, CMP_NONE, B_REG, 1'b0), m0, wb_alu, NPC_PLUS4);
		add_row(x_form(XO_AND, 1'b1), ex_exp(ALU_AND, EXT_SIGNED, CMP_NONE, B_REG, 1'b0),
			m0, wb_exp(1'b1, WD_ALU, 1'b1, 1'b1), NPC_PLUS4);
		add_row(x_form(XO_OR, 1'b0), ex_exp(ALU_OR, EXT_SIGNED, CMP_NONE, B_REG, 1'b0),
			m0, wb_lg, NPC_PLUS4);
		add_row(x_form(XO_XOR, 1'b0), ex_exp(ALU_XOR, EXT_SIGNED, CMP_NONE, B_REG, 1'b0),
			m0, wb_lg, NPC_PLUS4);
		add_row(x_form(XO_CMP, 1'b0), ex_exp(ALU_ADD, EXT_SIGNED, CMP_CMP, B_REG, 1'b0),
			m0, wb_cr, NPC_PLUS4);
		add_row(x_form(XO_CMPL, 1'b0), ex_exp(ALU_ADD, EXT_SIGNED, CMP_CMPL, B_REG, 1'b0),
			m0, wb_cr, NPC_PLUS4);
		add_row(d_form(OPCD_CMPI, 5'd0, 5'd4, 16'hfff0),
			ex_exp(ALU_ADD, EXT_SIGNED, CMP_CMP, B_IMM, 1'b0), m0, wb_cr, NPC_PLUS4);
		add_row(d_form(OPCD_CMPLI, 5'd0, 5'd4, 16'h8000),
			ex_exp(ALU_ADD, EXT_UNSIGN, CMP_CMPL, B_IMM, 1'b0), m0, wb_cr, NPC_PLUS4);
		add_row(d_form(OPCD_LWZ, 5'd6, 5'd1, 16'h0008), ex_ls,
			mem_exp(1'b0, LD_LW, ST_NONE), wb_ld, NPC_PLUS4);
		add_row(d_form(OPCD_LHZ, 5'd6, 5'd1, 16'h000a), ex_ls,
			mem_exp(1'b0, LD_LH, ST_NONE), wb_ld, NPC_PLUS4);
		add_row(d_form(OPCD_LHA, 5'd6, 5'd1, 16'h000c), ex_ls,
			mem_exp(1'b0, LD_LHA, ST_NONE), wb_ld, NPC_PLUS4);
		add_row(d_form(OPCD_LBZ, 5'd6, 5'd1, 16'h000d), ex_ls,
			mem_exp(1'b0, LD_LB, ST_NONE), wb_ld, NPC_PLUS4);
		add_row(d_form(OPCD_STW, 5'd7, 5'd1, 16'h0010), ex_ls,
			mem_exp(1'b1, LD_NONE, ST_SW), wb_none, NPC_PLUS4);
		add_row(d_form(OPCD_STH, 5'd7, 5'd1, 16'h0014), ex_ls,
			mem_exp(1'b1, LD_NONE, ST_SH), wb_none, NPC_PLUS4);
		add_row(d_form(OPCD_STB, 5'd7, 5'd1, 16'h0017), ex_ls,
			mem_exp(1'b1, LD_NONE, ST_SB), wb_none, NPC_PLUS4);
		add_row(INSTR_NOP, ex_nop, m0, wb_nop, NPC_PLUS4);
		add_row({OPCD_B, 24'h000010, 2'b00}, ex_rr, m0, wb_none, NPC_B);
		add_row(d_form(OPCD_ADDI, 5'd8, 5'd0, 16'h0001), ex_ri, m0, wb_alu, NPC_PLUS4);
		add_row(d_form(OPCD_BC, 5'd12, 5'd2, 16'h0020), ex_rr, m0, wb_none, NPC_BC);
		add_row(xo_form(XOXO_ADD, 1'b0), ex_rr, m0, wb_alu, NPC_PLUS4);
		add_row(d_form(OPCD_STW, 5'd7, 5'd1, 16'h0020), ex_ls,
			mem_exp(1'b1, LD_NONE, ST_SW), wb_none, NPC_PLUS4);
	endtask

	task automatic value_error(string name, logic [31:0] got, logic [31:0] exp);
		$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		$display("TESTBENCH FAILED");
		$fatal(1, "output mismatch");
	endtask

	task automatic check_idle();
		assert (!valid_d && !valid_e && !valid_mb && !valid_me && !valid_w)
			else value_error("valids", 32'({valid_d, valid_e, valid_mb, valid_me, valid_w}), 0);
		assert (!br_flush && !mem_ctrl.dm_wr && !wb_ctrl.gpr_wr && !wb_ctrl.cr_wr)
			else value_error("enables in reset",
				32'({br_flush, mem_ctrl.dm_wr, wb_ctrl.gpr_wr, wb_ctrl.cr_wr}), 0);
	endtask

	// hist[$] is the D slot and hist[$-n] is n edges older
	task automatic check_outputs();
		slot_t   d, e, mb, me, w;
		logic    exp_flush;
		npc_op_e exp_npc;
		d  = hist[$];
		e  = hist[$-1];
		mb = hist[$-2];
		me = hist[$-3];
		w  = hist[$-4];
		exp_flush = d.valid && (d.npc != NPC_PLUS4);
		exp_npc   = exp_flush ? d.npc : NPC_PLUS4;
		assert (valid_d == d.valid) else value_error("valid_d", 32'(valid_d), 32'(d.valid));
		assert (br_flush == exp_flush)
			else value_error("br_flush", 32'(br_flush), 32'(exp_flush));
		assert (npc_op == exp_npc) else value_error("npc_op", 32'(npc_op), 32'(exp_npc));
		assert (valid_e == e.valid) else value_error("valid_e", 32'(valid_e), 32'(e.valid));
		if (e.valid)
			assert (ex_ctrl == e.ex) else value_error("ex_ctrl", 32'(ex_ctrl), 32'(e.ex));
		assert (valid_mb == mb.valid)
			else value_error("valid_mb", 32'(valid_mb), 32'(mb.valid));
		assert (valid_me == me.valid)
			else value_error("valid_me", 32'(valid_me), 32'(me.valid));
		if (me.valid)
			assert (mem_ctrl == me.mem)
				else value_error("mem_ctrl", 32'(mem_ctrl), 32'(me.mem));
		else
			assert (!mem_ctrl.dm_wr) else value_error("dm_wr", 32'(mem_ctrl.dm_wr), 0);
		assert (valid_w == w.valid) else value_error("valid_w", 32'(valid_w), 32'(w.valid));
		if (w.valid)
			assert (wb_ctrl == w.wb) else value_error("wb_ctrl", 32'(wb_ctrl), 32'(w.wb));
		else
			assert (!wb_ctrl.gpr_wr && !wb_ctrl.cr_wr)
				else value_error("gpr_wr/cr_wr", 32'({wb_ctrl.gpr_wr, wb_ctrl.cr_wr}), 0);
	endtask

	initial begin
		slot_t  slot;
		instr_t word;
		int     c;
		int     row;
		int     drain;
		int     inv_cnt;
		seed    = 32'hfd40_7bc2;
		rst_n   = 1'b0;
		instr_d = INSTR_NOP;
		n_rows  = 0;
		c       = 0;
		row     = 0;
		drain   = 0;
		inv_cnt = 0;
		foreach (killed[i])
			killed[i] = 1'b0;
		fill_table();
		repeat (4) hist.push_back('0); // pipeline empty out of reset
		repeat (3) begin
			@(negedge clk);
			check_idle();
		end
		while (drain < 4) begin
			@(posedge clk);
			if (c == 0)
				rst_n <= 1'b1;
			slot = '0;
			slot.valid = (c != 0) && !killed[c];
			if (slot.valid && row < n_rows) begin
				instr_d <= table_rows[row].word;
				slot.ex  = table_rows[row].ex;
				slot.mem = table_rows[row].mem;
				slot.wb  = table_rows[row].wb;
				slot.npc = table_rows[row].npc;
				if (slot.npc != NPC_PLUS4) begin
					killed[c + 2] = 1'b1; // slot after the delay slot
					killed[c + 3] = 1'b1;
				end
				row++;
			end else if (slot.valid) begin
				instr_d <= INSTR_NOP; // drain
				slot.ex  = ex_exp(ALU_OR, EXT_UNSIGN, CMP_NONE, B_REG, 1'b0);
				slot.wb  = wb_exp(1'b0, WD_ALU, 1'b1, 1'b0);
				slot.npc = NPC_PLUS4;
				drain++;
			end else begin
				// junk in dead slots cycles through a branch, a store and andi.
				word = $random(seed);
				case (inv_cnt % 3)
					0:       word[OPCD_MSB +: 6] = OPCD_B;
					1:       word[OPCD_MSB +: 6] = OPCD_STW;
					default: word[OPCD_MSB +: 6] = OPCD_ANDI;
				endcase
				inv_cnt++;
				instr_d <= word;
			end
			hist.push_back(slot);
			@(negedge clk);
			check_outputs();
			c++;
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* src.f */
verilog/ppc_ctrl_pkg.sv
verilog/instr_decoder.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/writeback_stage.sv
verilog/pipe_ctrl_top.sv
bench/pipe_ctrl_asserts.sv
bench/pipe_ctrl_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = pipe_ctrl_tb
FILELIST  = src.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
